// ==== action_exec_pkg.sv ====
`default_nettype none

package action_exec_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int HDR_WIDTH   = 512; // Packet header descriptor
  localparam int POS_WIDTH   = 9;   // Enough to address any header bit
  localparam int TAG_WIDTH   = 5;
  localparam int FLAG_WIDTH  = 16;
  localparam int FIELD_COUNT = 15;  // Rewritable fields, flag bits 0 to 14

  typedef logic [HDR_WIDTH-1:0]  hdr_t;
  typedef logic [POS_WIDTH-1:0]  bit_pos_t;
  typedef logic [TAG_WIDTH-1:0]  flow_tag_t;
  typedef logic [FLAG_WIDTH-1:0] action_flag_t;

  // One type per header field width
  typedef logic [31:0] egress_port_t;
  typedef logic [63:0] metadata_t;
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ether_type_t;
  typedef logic [11:0] vlan_id_t;
  typedef logic [2:0]  vlan_pcp_t;
  typedef logic [19:0] mpls_label_t;
  typedef logic [2:0]  mpls_tc_t;
  typedef logic [31:0] ipv4_addr_t;
  typedef logic [7:0]  ip_proto_t;
  typedef logic [5:0]  ip_tos_t;   // DSCP only, no ECN bits
  typedef logic [15:0] l4_port_t;

  ////////////////////////////////////////////////////////////
  // Action set, 356 bits, egress port at the top
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    egress_port_t egress_port;
    metadata_t    metadata;
    mac_addr_t    dst_mac;
    mac_addr_t    src_mac;
    ether_type_t  ether_type;
    vlan_id_t     vlan_id;
    vlan_pcp_t    vlan_pcp;
    mpls_label_t  mpls_label;
    mpls_tc_t     mpls_tc;
    ipv4_addr_t   src_ipv4;
    ipv4_addr_t   dst_ipv4;
    ip_proto_t    ip_proto;
    ip_tos_t      ip_tos;
    l4_port_t     tcp_src;
    l4_port_t     tcp_dst;
  } action_set_t;

  // Runtime field locations, each the MSB of its field in the header
  typedef struct packed {
    bit_pos_t egress_port;
    bit_pos_t metadata;
    bit_pos_t dst_mac;
    bit_pos_t src_mac;
    bit_pos_t ether_type;
    bit_pos_t vlan_id;
    bit_pos_t vlan_pcp;
    bit_pos_t mpls_label;
    bit_pos_t mpls_tc;
    bit_pos_t src_ipv4;
    bit_pos_t dst_ipv4;
    bit_pos_t ip_proto;
    bit_pos_t ip_tos;
    bit_pos_t tcp_src;
    bit_pos_t tcp_dst;
  } field_loc_t;

  ////////////////////////////////////////////////////////////
  // Action flag bits
  ////////////////////////////////////////////////////////////

  localparam int FLAG_EGRESS_PORT = 0;
  localparam int FLAG_METADATA    = 1;
  localparam int FLAG_DST_MAC     = 2;
  localparam int FLAG_SRC_MAC     = 3;
  localparam int FLAG_ETHER_TYPE  = 4;
  localparam int FLAG_VLAN_ID     = 5;
  localparam int FLAG_VLAN_PCP    = 6;
  localparam int FLAG_MPLS_LABEL  = 7;
  localparam int FLAG_MPLS_TC     = 8;
  localparam int FLAG_SRC_IPV4    = 9;
  localparam int FLAG_DST_IPV4    = 10;
  localparam int FLAG_IP_PROTO    = 11;
  localparam int FLAG_IP_TOS      = 12;
  localparam int FLAG_TCP_SRC     = 13;
  localparam int FLAG_TCP_DST     = 14;
  localparam int FLAG_DROP        = 15; // Packet is discarded, not rewritten away

endpackage

`default_nettype wire

// ==== field_patch.sv ====
`timescale 1ns/1ps
`default_nettype none

// Places one field value at a runtime position inside a header-wide vector
module field_patch import action_exec_pkg::*; #(
  parameter int FIELD_WIDTH = 8
) (
  input  bit_pos_t               pos,   // MSB of the field
  input  logic [FIELD_WIDTH-1:0] value,
  input  logic                   apply,
  output hdr_t                   mask,
  output hdr_t                   bits
);

  localparam bit_pos_t SPAN = bit_pos_t'(FIELD_WIDTH - 1);

  bit_pos_t lsb;

  assign lsb = pos - SPAN; // Field runs from pos down to here

  always_comb begin
    mask = '0;
    bits = '0;
    if (apply) begin
      mask = hdr_t'({FIELD_WIDTH{1'b1}}) << lsb;
      bits = hdr_t'(value) << lsb;
      // Position too low would wrap the field past bit 0
      assert (pos >= SPAN)
        else $error("field_patch: pos %0d too low for width %0d", pos, FIELD_WIDTH);
    end
  end

endmodule

`default_nettype wire

// ==== action_apply.sv ====
`timescale 1ns/1ps
`default_nettype none

module action_apply import action_exec_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  hdr_t         hdr_in,
  input  action_flag_t action_flag,
  input  action_set_t  action_set,
  input  field_loc_t   field_loc,
  output hdr_t         hdr_next
);

  hdr_t mask [FIELD_COUNT];
  hdr_t bits [FIELD_COUNT];
  hdr_t mask_all;
  hdr_t bits_all;
  logic overlap;

  ////////////////////////////////////////////////////////////
  // One patch per field, flag index doubles as array index
  ////////////////////////////////////////////////////////////

  field_patch #(.FIELD_WIDTH($bits(egress_port_t))) u_egress_port (
    .pos(field_loc.egress_port), .value(action_set.egress_port),
    .apply(action_flag[FLAG_EGRESS_PORT]),
    .mask(mask[FLAG_EGRESS_PORT]), .bits(bits[FLAG_EGRESS_PORT]));
  field_patch #(.FIELD_WIDTH($bits(metadata_t))) u_metadata (
    .pos(field_loc.metadata), .value(action_set.metadata),
    .apply(action_flag[FLAG_METADATA]),
    .mask(mask[FLAG_METADATA]), .bits(bits[FLAG_METADATA]));
  field_patch #(.FIELD_WIDTH($bits(mac_addr_t))) u_dst_mac (
    .pos(field_loc.dst_mac), .value(action_set.dst_mac),
    .apply(action_flag[FLAG_DST_MAC]),
    .mask(mask[FLAG_DST_MAC]), .bits(bits[FLAG_DST_MAC]));
  field_patch #(.FIELD_WIDTH($bits(mac_addr_t))) u_src_mac (
    .pos(field_loc.src_mac), .value(action_set.src_mac),
    .apply(action_flag[FLAG_SRC_MAC]),
    .mask(mask[FLAG_SRC_MAC]), .bits(bits[FLAG_SRC_MAC]));
  field_patch #(.FIELD_WIDTH($bits(ether_type_t))) u_ether_type (
    .pos(field_loc.ether_type), .value(action_set.ether_type),
    .apply(action_flag[FLAG_ETHER_TYPE]),
    .mask(mask[FLAG_ETHER_TYPE]), .bits(bits[FLAG_ETHER_TYPE]));
  field_patch #(.FIELD_WIDTH($bits(vlan_id_t))) u_vlan_id (
    .pos(field_loc.vlan_id), .value(action_set.vlan_id),
    .apply(action_flag[FLAG_VLAN_ID]),
    .mask(mask[FLAG_VLAN_ID]), .bits(bits[FLAG_VLAN_ID]));
  field_patch #(.FIELD_WIDTH($bits(vlan_pcp_t))) u_vlan_pcp (
    .pos(field_loc.vlan_pcp), .value(action_set.vlan_pcp),
    .apply(action_flag[FLAG_VLAN_PCP]),
    .mask(mask[FLAG_VLAN_PCP]), .bits(bits[FLAG_VLAN_PCP]));
  field_patch #(.FIELD_WIDTH($bits(mpls_label_t))) u_mpls_label (
    .pos(field_loc.mpls_label), .value(action_set.mpls_label),
    .apply(action_flag[FLAG_MPLS_LABEL]),
    .mask(mask[FLAG_MPLS_LABEL]), .bits(bits[FLAG_MPLS_LABEL]));
  field_patch #(.FIELD_WIDTH($bits(mpls_tc_t))) u_mpls_tc (
    .pos(field_loc.mpls_tc), .value(action_set.mpls_tc),
    .apply(action_flag[FLAG_MPLS_TC]),
    .mask(mask[FLAG_MPLS_TC]), .bits(bits[FLAG_MPLS_TC]));
  field_patch #(.FIELD_WIDTH($bits(ipv4_addr_t))) u_src_ipv4 (
    .pos(field_loc.src_ipv4), .value(action_set.src_ipv4),
    .apply(action_flag[FLAG_SRC_IPV4]),
    .mask(mask[FLAG_SRC_IPV4]), .bits(bits[FLAG_SRC_IPV4]));
  field_patch #(.FIELD_WIDTH($bits(ipv4_addr_t))) u_dst_ipv4 (
    .pos(field_loc.dst_ipv4), .value(action_set.dst_ipv4),
    .apply(action_flag[FLAG_DST_IPV4]),
    .mask(mask[FLAG_DST_IPV4]), .bits(bits[FLAG_DST_IPV4]));
  field_patch #(.FIELD_WIDTH($bits(ip_proto_t))) u_ip_proto (
    .pos(field_loc.ip_proto), .value(action_set.ip_proto),
    .apply(action_flag[FLAG_IP_PROTO]),
    .mask(mask[FLAG_IP_PROTO]), .bits(bits[FLAG_IP_PROTO]));
  field_patch #(.FIELD_WIDTH($bits(ip_tos_t))) u_ip_tos (
    .pos(field_loc.ip_tos), .value(action_set.ip_tos),
    .apply(action_flag[FLAG_IP_TOS]),
    .mask(mask[FLAG_IP_TOS]), .bits(bits[FLAG_IP_TOS]));
  field_patch #(.FIELD_WIDTH($bits(l4_port_t))) u_tcp_src (
    .pos(field_loc.tcp_src), .value(action_set.tcp_src),
    .apply(action_flag[FLAG_TCP_SRC]),
    .mask(mask[FLAG_TCP_SRC]), .bits(bits[FLAG_TCP_SRC]));
  field_patch #(.FIELD_WIDTH($bits(l4_port_t))) u_tcp_dst (
    .pos(field_loc.tcp_dst), .value(action_set.tcp_dst),
    .apply(action_flag[FLAG_TCP_DST]),
    .mask(mask[FLAG_TCP_DST]), .bits(bits[FLAG_TCP_DST]));

  // Merge patches; any bit claimed twice flags an overlap
  always_comb begin
    mask_all = '0;
    bits_all = '0;
    overlap  = 1'b0;
    for (int i = 0; i < FIELD_COUNT; i++) begin
      overlap  = overlap | (|(mask_all & mask[i]));
      mask_all = mask_all | mask[i];
      bits_all = bits_all | bits[i];
    end
  end

  assign hdr_next = (hdr_in & ~mask_all) | bits_all;

  // Location table must keep applied fields apart
  a_no_overlap: assert property (@(posedge clk) disable iff (!reset)
    (action_flag[FIELD_COUNT-1:0] != '0) |-> !overlap)
    else $error("action_apply: applied fields overlap, flags %h", action_flag);

endmodule

`default_nettype wire

// ==== exec_output_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_output_reg import action_exec_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      prog_en,  // Freeze outputs while high
  input  logic      exec_en,
  input  logic      drop,
  input  hdr_t      hdr_next,
  input  flow_tag_t tag_in,
  output hdr_t      hdr_out,
  output flow_tag_t tag_out,
  output logic      pkt_out_en
);

  ////////////////////////////////////////////////////////////
  // Output stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      hdr_out    <= '0;
      tag_out    <= '0;
      pkt_out_en <= 1'b0;
    end else if (prog_en) begin
      // Hold everything during table programming
      hdr_out    <= hdr_out;
      tag_out    <= tag_out;
      pkt_out_en <= pkt_out_en;
    end else if (exec_en) begin
      hdr_out    <= hdr_next;     // Registered even when dropped
      tag_out    <= tag_in;
      pkt_out_en <= ~drop;
    end else begin
      // Idle cycle clears the outputs
      hdr_out    <= '0;
      tag_out    <= '0;
      pkt_out_en <= 1'b0;
    end
  end

  // No packet may leave on the edge right after reset
  a_quiet_after_reset: assert property (@(posedge clk)
    !reset |=> !pkt_out_en)
    else $error("exec_output_reg: pkt_out_en high after reset");

endmodule

`default_nettype wire

// ==== action_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module action_exec_top import action_exec_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         prog_en,
  input  logic         exec_en,
  input  hdr_t         hdr_in,
  input  action_flag_t action_flag,
  input  action_set_t  action_set,
  input  field_loc_t   field_loc,
  input  flow_tag_t    tag_in,
  output hdr_t         hdr_out,
  output logic         pkt_out_en,
  output flow_tag_t    tag_out
);

  hdr_t hdr_next;  // Rewritten header, same cycle
  logic drop;

  assign drop = action_flag[FLAG_DROP];

  action_apply u_apply (
    .clk         (clk),
    .reset       (reset),
    .hdr_in      (hdr_in),
    .action_flag (action_flag),
    .action_set  (action_set),
    .field_loc   (field_loc),
    .hdr_next    (hdr_next)
  );

  // One register stage to the outputs
  exec_output_reg u_out_reg (
    .clk        (clk),
    .reset      (reset),
    .prog_en    (prog_en),
    .exec_en    (exec_en),
    .drop       (drop),
    .hdr_next   (hdr_next),
    .tag_in     (tag_in),
    .hdr_out    (hdr_out),
    .tag_out    (tag_out),
    .pkt_out_en (pkt_out_en)
  );

endmodule

`default_nettype wire

// ==== tb_action_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_action_exec import action_exec_pkg::*; ();

  localparam int          CLK_PERIOD    = 100;
  localparam int          RESET_CYCLES  = 5;
  localparam int          RANDOM_CYCLES = 200;
  localparam int          MAX_CYCLES    = 400;
  localparam logic [31:0] SEED          = 32'd81594;

  // Field widths in flag order, egress port first
  localparam int FIELD_W [FIELD_COUNT] = '{32, 64, 48, 48, 16, 12, 3, 20, 3, 32, 32, 8, 6, 16, 16};

  logic         clk;
  logic         reset;
  logic         prog_en;
  logic         exec_en;
  hdr_t         hdr_in;
  action_flag_t action_flag;
  action_set_t  action_set;
  field_loc_t   field_loc;
  flow_tag_t    tag_in;
  hdr_t         hdr_out;
  logic         pkt_out_en;
  flow_tag_t    tag_out;

  hdr_t      exp_hdr;
  flow_tag_t exp_tag;
  logic      exp_en;
  logic      started = 1'b0;    // Model has seen its first edge
  logic [31:0] lfsr  = SEED;

  int hdr_errors  = 0;
  int tag_errors  = 0;
  int en_errors   = 0;
  int rule_errors = 0;

  action_exec_top dut (
    .clk         (clk),
    .reset       (reset),
    .prog_en     (prog_en),
    .exec_en     (exec_en),
    .hdr_in      (hdr_in),
    .action_flag (action_flag),
    .action_set  (action_set),
    .field_loc   (field_loc),
    .tag_in      (tag_in),
    .hdr_out     (hdr_out),
    .pkt_out_en  (pkt_out_en),
    .tag_out     (tag_out)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic hdr_t rand_bits(input int n);
    hdr_t r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[HDR_WIDTH-2:0], rand_bit()};
    return r;
  endfunction

  // Fields packed back to back from the header MSB down
  function automatic field_loc_t top_packed_layout();
    field_loc_t loc;
    int         msb;
    loc = '0;
    msb = HDR_WIDTH - 1;
    for (int i = 0; i < FIELD_COUNT; i++) begin
      loc[(FIELD_COUNT-1-i)*POS_WIDTH +: POS_WIDTH] = bit_pos_t'(msb);
      msb = msb - FIELD_W[i];
    end
    return loc;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;                          // Inputs change just after the edge
  endtask

  task automatic drive_random(input action_flag_t flags);
    hdr_t r;
    hdr_in      = rand_bits(HDR_WIDTH);
    r           = rand_bits($bits(action_set_t));
    action_set  = r[$bits(action_set_t)-1:0];
    r           = rand_bits(TAG_WIDTH);
    tag_in      = r[TAG_WIDTH-1:0];
    action_flag = flags;
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // LSB of field i inside the action set
  function automatic int set_offset(input int i);
    int off;
    off = 0;
    for (int j = i + 1; j < FIELD_COUNT; j++)
      off = off + FIELD_W[j];
    return off;
  endfunction

  function automatic hdr_t expected_rewrite(input hdr_t hdr, input action_flag_t flags,
                                            input action_set_t aset, input field_loc_t loc);
    hdr_t r;
    int   msb;
    int   off;
    r = hdr;
    for (int i = 0; i < FIELD_COUNT; i++) begin
      if (flags[i]) begin
        msb = int'(loc[(FIELD_COUNT-1-i)*POS_WIDTH +: POS_WIDTH]);
        off = set_offset(i);
        for (int b = 0; b < FIELD_W[i]; b++)
          r[msb - b] = aset[off + FIELD_W[i] - 1 - b]; // Bit by bit, MSB first
      end
    end
    return r;
  endfunction

  always @(posedge clk) begin
    started <= 1'b1;
    if (!reset) begin
      exp_hdr <= '0;
      exp_tag <= '0;
      exp_en  <= 1'b0;
    end else if (prog_en) begin
      exp_hdr <= exp_hdr;        // Frozen
      exp_tag <= exp_tag;
      exp_en  <= exp_en;
    end else if (exec_en) begin
      exp_hdr <= expected_rewrite(hdr_in, action_flag, action_set, field_loc);
      exp_tag <= tag_in;
      exp_en  <= ~action_flag[FLAG_DROP];
    end else begin
      exp_hdr <= '0;
      exp_tag <= '0;
      exp_en  <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Compared mid-cycle, away from the edge
  a_hdr_match: assert property (@(negedge clk) (!started || (hdr_out == exp_hdr)))
    else begin
      hdr_errors++;
      $display("Error at %0t: hdr_out is %h, expected %h", $time, hdr_out, exp_hdr);
    end

  a_tag_match: assert property (@(negedge clk) (!started || (tag_out == exp_tag)))
    else begin
      tag_errors++;
      $display("Error at %0t: tag_out is %h, expected %h", $time, tag_out, exp_tag);
    end

  a_en_match: assert property (@(negedge clk) (!started || (pkt_out_en == exp_en)))
    else begin
      en_errors++;
      $display("Error at %0t: pkt_out_en is %b, expected %b", $time, pkt_out_en, exp_en);
    end

  a_idle_clears: assert property (@(posedge clk) disable iff (!reset)
    (!prog_en && !exec_en) |=> (hdr_out == '0 && tag_out == '0 && !pkt_out_en))
    else begin
      rule_errors++;
      $display("Error at %0t: hdr_out is %h, tag_out is %h, pkt_out_en is %b, expected 0",
               $time, $sampled(hdr_out), $sampled(tag_out), $sampled(pkt_out_en));
    end

  a_drop_blocks: assert property (@(posedge clk) disable iff (!reset)
    (exec_en && !prog_en && action_flag[FLAG_DROP]) |=> !pkt_out_en)
    else begin
      rule_errors++;
      $display("Error at %0t: pkt_out_en is 1 after a dropped packet, expected 0", $time);
    end

  a_prog_holds: assert property (@(posedge clk) disable iff (!reset)
    prog_en |=> ($stable(hdr_out) && $stable(tag_out) && $stable(pkt_out_en)))
    else begin
      rule_errors++;
      $display("Outputs changed while programming was enabled at %0t", $time);
    end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    hdr_t r;
    reset       = 1'b0;
    prog_en     = 1'b0;
    exec_en     = 1'b0;
    hdr_in      = '0;
    action_flag = '0;
    action_set  = '0;
    tag_in      = '0;
    field_loc   = top_packed_layout();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b1;

    repeat (4) begin             // Idle with live data on the inputs
      drive_random('0);
      next_cycle();
    end

    exec_en = 1'b1;
    repeat (10) begin            // Plain forwarding, no flags
      drive_random('0);
      next_cycle();
    end

    repeat (RANDOM_CYCLES) begin
      r = rand_bits(FIELD_COUNT);
      drive_random({1'b0, r[FIELD_COUNT-1:0]});
      next_cycle();
    end

    // Dropped packets still rewrite the header
    repeat (20) begin
      r = rand_bits(FIELD_COUNT);
      drive_random({1'b1, r[FIELD_COUNT-1:0]});
      next_cycle();
    end

    drive_random(16'h0005);
    next_cycle();
    prog_en = 1'b1;
    repeat (10) begin
      r       = rand_bits(FLAG_WIDTH + 1);
      exec_en = r[FLAG_WIDTH];
      drive_random(r[FLAG_WIDTH-1:0]);
      next_cycle();
    end
    prog_en = 1'b0;
    exec_en = 1'b1;

    for (int f = 0; f < FIELD_COUNT; f++) begin
      drive_random(action_flag_t'(1) << f); // One field at a time
      next_cycle();
    end

    exec_en = 1'b0;
    drive_random('0);
    repeat (2) next_cycle();
    @(negedge clk);
    #1;

    $display("Errors: hdr_out %0d, tag_out %0d, pkt_out_en %0d, rules %0d",
             hdr_errors, tag_errors, en_errors, rule_errors);
    if (hdr_errors + tag_errors + en_errors + rule_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(CLK_PERIOD * (MAX_CYCLES + 20));
    $display("Watchdog expired, the test sequence did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
action_exec_pkg.sv
field_patch.sv
action_apply.sv
exec_output_reg.sv
action_exec_top.sv
tb_action_exec.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the action engine testbench with Verilator

LOG=sim.log

rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_action_exec -o tb_action_exec \
  && ./obj_dir/tb_action_exec > "$LOG" 2>&1

cat "$LOG" 2>/dev/null

grep -qx '\*\*\* PASSED \*\*\*' "$LOG" 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see $LOG"; exit 1; }

exit 0
